/* sources.f */
+incdir+test
common/scope_cfg_pkg.sv
common/scope_data_pkg.sv
source/scope_regs.sv
source/trigger_detect.sv
source/sample_counter.sv
source/capture_fsm.sv
capture/capture_buffer.sv
capture/dma_writer.sv
source/uscope_top.sv
test/uscope_tb.sv

/* test/scope_ref.svh */
// Reference model for the scope capture window
// Finds the trigger strobe in the recorded sample history and
// builds the 64 expected output words, oldest slot first

`ifndef SCOPE_REF_SVH
`define SCOPE_REF_SVH

// Returns the history index of the trigger strobe, or -1 when the history
// holds no trigger or not the full window around it
function automatic int build_window(
    input  scope_data_pkg::slot_t     hist [$],
    input  scope_data_pkg::slot_t     prior,
    input  bit                        prior_valid,
    input  scope_cfg_pkg::scope_cfg_t cfg,
    output scope_data_pkg::out_word_t words [scope_cfg_pkg::buffer_depth]
);
    int                      i;
    int                      k;
    int                      trig;
    int                      first;
    bit                      have_prev;
    scope_data_pkg::sample_t cur;
    scope_data_pkg::sample_t prev;
    scope_data_pkg::sample_t level;

    trig      = -1;
    level     = cfg.level;
    have_prev = prior_valid;
    prev      = prior.ch[cfg.channel];

    // The first trig_point strobes after arm fill the pre-trigger part
    // and cannot trigger, but they still count as previous samples
    for (i = 0; i < hist.size(); i++) begin
        cur = hist[i].ch[cfg.channel];
        if (trig < 0 && i >= int'(cfg.trig_point) && have_prev
            && cur >= level && prev < level) begin
            trig = i;
        end
        prev      = cur;
        have_prev = 1'b1;
    end

    first = trig - int'(cfg.trig_point);
    if (trig >= 0 && first + scope_cfg_pkg::buffer_depth > hist.size()) begin
        trig = -1;
    end

    for (k = 0; k < scope_cfg_pkg::buffer_depth; k++) begin
        words[k].addr = cfg.base_addr + 32'(8 * k);
        words[k].data = (trig >= 0) ? hist[first + k] : '0;
    end
    return trig;
endfunction

`endif

/* test/uscope_tb.sv */
// Testbench for the scope capture subsystem
// Clock and reset, sample stream driver, sample monitor,
// output word checker and the capture test sequence

`timescale 1ns/1ps

module uscope_tb;

    localparam int done_timeout = 4000;

    logic                      clock;
    logic                      rst;
    logic                      reg_write;
    scope_cfg_pkg::reg_addr_t  reg_addr;
    logic [31:0]               reg_data;
    logic                      sample_valid;
    scope_data_pkg::slot_t     sample_data;
    logic                      out_valid;
    scope_data_pkg::out_word_t out_word;
    logic                      dma_done;
    logic                      busy;

    scope_cfg_pkg::scope_cfg_t cur_cfg;
    scope_data_pkg::slot_t     hist [$];
    scope_data_pkg::slot_t     last_slot;
    scope_data_pkg::slot_t     prior_slot;
    scope_data_pkg::out_word_t exp_words [scope_cfg_pkg::buffer_depth];
    bit                        last_valid;
    bit                        prior_valid;
    bit                        last_out_valid;
    bit                        expecting;
    bit                        streaming;
    bit                        use_random;
    string                     test_name;
    int                        word_count;
    int                        done_count;
    int                        sample_index;
    int                        phase_count;

    `include "scope_ref.svh"

    uscope_top uscope_top_i (
        .clock        (clock),
        .rst          (rst),
        .reg_write    (reg_write),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .out_valid    (out_valid),
        .out_word     (out_word),
        .dma_done     (dma_done),
        .busy         (busy)
    );

    always #10 clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic next_cycle;
        @(posedge clock);
        #1;
    endtask

    // Sawtooth per channel with a channel dependent phase, or random values
    // Sawtooth ranges of neighbouring channels overlap, so one level is
    // crossed by several channels
    function automatic scope_data_pkg::slot_t make_slot(input int n, input bit random_data);
        scope_data_pkg::slot_t s;
        int                    c;
        int                    v;
        for (c = 0; c < scope_cfg_pkg::n_channels; c++) begin
            v       = random_data ? int'($urandom % 800) : ((n + 7 * c) * 113) % 2400;
            s.ch[c] = 16'(v + 1000 * c);
        end
        return s;
    endfunction

    // One strobe every 4th cycle while streaming is on
    initial begin : stream_driver
        bit go;
        void'($urandom(65));
        forever begin
            @(posedge clock);
            go = streaming;
            #1;
            phase_count = (phase_count + 1) % 4;
            if (go && phase_count == 0) begin
                sample_valid = 1'b1;
                sample_data  = make_slot(sample_index, use_random);
                sample_index++;
            end else begin
                sample_valid = 1'b0;
            end
        end
    end

    always @(posedge clock) begin : sample_monitor
        if (rst) begin
            last_valid = 1'b0;
        end else if (sample_valid) begin
            if (expecting) begin
                hist.push_back(sample_data);
            end
            last_slot  = sample_data;
            last_valid = 1'b1;
        end
    end

    always @(posedge clock) begin : word_checker
        int trig;
        if (out_valid) begin
            assert (expecting) else fail_run("out_valid seen while no capture was armed");
            if (word_count == 0) begin
                trig = build_window(hist, prior_slot, prior_valid, cur_cfg, exp_words);
                assert (trig >= 0) else fail_run("no complete trigger window in the history");
            end
            assert (word_count < scope_cfg_pkg::buffer_depth)
                else fail_run("more output words than buffer slots");
            assert (out_word === exp_words[word_count])
                else fail_run($sformatf("** Error [%s] word %0d: expected %h, actual %h",
                                        test_name, word_count, exp_words[word_count], out_word));
            word_count++;
        end else begin
            assert (word_count == 0 || word_count >= scope_cfg_pkg::buffer_depth)
                else fail_run("output words did not arrive on consecutive cycles");
        end
        if (dma_done) begin
            assert (word_count == scope_cfg_pkg::buffer_depth && last_out_valid)
                else fail_run("dma_done did not follow the last output word");
            done_count++;
        end
        last_out_valid = out_valid;
    end

    task automatic write_reg(input scope_cfg_pkg::reg_addr_t addr, input logic [31:0] data);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_data  = data;
        next_cycle();
        reg_write = 1'b0;
    endtask

    task automatic wait_for_done;
        int cycles;
        cycles = 0;
        while (!dma_done) begin
            next_cycle();
            cycles++;
            assert (cycles < done_timeout) else fail_run("timeout waiting for dma_done");
        end
        cycles = 0;
        while (busy) begin
            next_cycle();
            cycles++;
            assert (cycles < 8) else fail_run("busy stayed high after dma_done");
        end
    endtask

    task automatic run_capture(input string name, input logic [31:0] base,
                               input logic [15:0] level, input logic [1:0] channel,
                               input int tp, input bit random_data);
        test_name          = name;
        use_random         = random_data;
        cur_cfg.base_addr  = base;
        cur_cfg.level      = level;
        cur_cfg.channel    = channel;
        cur_cfg.trig_point = scope_cfg_pkg::index_t'(tp);
        write_reg(scope_cfg_pkg::addr_base, base);
        write_reg(scope_cfg_pkg::addr_level, 32'(level));
        write_reg(scope_cfg_pkg::addr_channel, 32'(channel));
        write_reg(scope_cfg_pkg::addr_pretrig, 32'(tp));

        // A few strobes under the new channel select give the detector its history
        streaming = 1'b1;
        repeat (12) next_cycle();
        streaming = 1'b0;
        repeat (3) next_cycle();

        prior_slot  = last_slot;
        prior_valid = last_valid;
        hist.delete();
        word_count = 0;
        done_count = 0;
        expecting  = 1'b1;
        write_reg(scope_cfg_pkg::addr_arm, 32'd0);
        repeat (2) next_cycle();
        streaming = 1'b1;
        wait_for_done();
        streaming = 1'b0;
        repeat (6) next_cycle();
        expecting = 1'b0;

        assert (word_count == scope_cfg_pkg::buffer_depth)
            else fail_run($sformatf("** Error [%s] word count: expected %0d, actual %0d",
                                    name, scope_cfg_pkg::buffer_depth, word_count));
        assert (done_count == 1)
            else fail_run($sformatf("** Error [%s] dma_done pulses: expected 1, actual %0d",
                                    name, done_count));
    endtask

    initial begin
        clock        = 1'b0;
        rst          = 1'b1;
        reg_write    = 1'b0;
        reg_addr     = '0;
        reg_data     = '0;
        sample_valid = 1'b0;
        sample_data  = '0;
        cur_cfg      = '0;
        streaming    = 1'b0;
        expecting    = 1'b0;
        use_random   = 1'b0;
        word_count   = 0;
        done_count   = 0;
        sample_index = 0;
        phase_count  = 0;
        repeat (3) next_cycle();
        rst = 1'b0;
        assert (!out_valid && !dma_done && !busy)
            else fail_run("outputs were not idle after reset");

        // Samples without an arm must leave the scope idle
        test_name = "no_arm";
        streaming = 1'b1;
        repeat (160) next_cycle();
        streaming = 1'b0;
        repeat (3) next_cycle();
        assert (!busy && word_count == 0) else fail_run("samples without arm started a capture");

        run_capture("basic_ch0_tp32", 32'h1000_0000, 16'd400, 2'd0, 32, 1'b0);
        run_capture("trig_point_0", 32'h1000_4000, 16'd1400, 2'd1, 0, 1'b1);
        run_capture("trig_point_63", 32'h1000_8000, 16'd3400, 2'd3, 63, 1'b1);
        run_capture("channel_2", 32'h1000_c000, 16'd2200, 2'd2, 10, 1'b0);
        run_capture("prefill_crossing", 32'h1001_0000, 16'd200, 2'd0, 50, 1'b0);
        run_capture("rearm_new_base", 32'h2000_0100, 16'd1600, 2'd1, 20, 1'b0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* source/uscope_top.sv */
// Scope capture subsystem top level
// Connects register file, trigger detector, counters, capture FSM,
// capture memory and readout engine

`timescale 1ns/1ps

module uscope_top (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      reg_write,
    input  scope_cfg_pkg::reg_addr_t  reg_addr,
    input  logic [31:0]               reg_data,
    input  logic                      sample_valid,
    input  scope_data_pkg::slot_t     sample_data,
    output logic                      out_valid,
    output scope_data_pkg::out_word_t out_word,
    output logic                      dma_done,
    output logic                      busy
);

    scope_cfg_pkg::scope_cfg_t cfg;
    scope_cfg_pkg::index_t     wr_ptr;
    scope_cfg_pkg::index_t     rd_addr;
    scope_data_pkg::slot_t     rd_data;
    logic                      arm;
    logic                      hit;
    logic                      prefill_done;
    logic                      post_done;
    logic                      count_clear;
    logic                      write_en;
    logic                      post_phase;
    logic                      start;

    scope_regs regs_i (
        .clock     (clock),
        .rst       (rst),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data),
        .cfg       (cfg),
        .arm       (arm)
    );

    trigger_detect trigger_i (
        .clock        (clock),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .cfg          (cfg),
        .hit          (hit)
    );

    sample_counter counter_i (
        .clock        (clock),
        .rst          (rst),
        .clear        (count_clear),
        .count_en     (write_en),
        .post_phase   (post_phase),
        .cfg          (cfg),
        .wr_ptr       (wr_ptr),
        .prefill_done (prefill_done),
        .post_done    (post_done)
    );

    capture_fsm fsm_i (
        .clock        (clock),
        .rst          (rst),
        .arm          (arm),
        .sample_valid (sample_valid),
        .hit          (hit),
        .prefill_done (prefill_done),
        .post_done    (post_done),
        .write_done   (dma_done),
        .count_clear  (count_clear),
        .write_en     (write_en),
        .post_phase   (post_phase),
        .start        (start),
        .busy         (busy)
    );

    capture_buffer buffer_i (
        .clock   (clock),
        .wr_en   (write_en),
        .wr_addr (wr_ptr),
        .wr_data (sample_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // After the final capture write the write pointer indexes the oldest slot
    dma_writer dma_i (
        .clock     (clock),
        .rst       (rst),
        .start     (start),
        .start_ptr (wr_ptr),
        .cfg       (cfg),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .out_valid (out_valid),
        .out_word  (out_word),
        .dma_done  (dma_done)
    );

endmodule

/* capture/dma_writer.sv */
// Readout engine
// Walks the capture buffer from the oldest slot, pairs each slot
// with its output address and signals the end with a done pulse

`timescale 1ns/1ps

module dma_writer (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      start,
    input  scope_cfg_pkg::index_t     start_ptr,
    input  scope_cfg_pkg::scope_cfg_t cfg,
    output scope_cfg_pkg::index_t     rd_addr,
    input  scope_data_pkg::slot_t     rd_data,
    output logic                      out_valid,
    output scope_data_pkg::out_word_t out_word,
    output logic                      dma_done
);

    scope_cfg_pkg::index_t rd_ptr;
    scope_cfg_pkg::index_t word_idx;
    scope_cfg_pkg::index_t issue_idx;
    logic                  active;
    logic                  issue;
    logic                  last_q;
    logic [31:0]           addr_q;

    // The first read goes out in the start cycle itself
    assign issue     = start || active;
    assign issue_idx = start ? '0 : word_idx;
    assign rd_addr   = start ? start_ptr : rd_ptr;

    assign out_word.addr = addr_q;
    assign out_word.data = rd_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            active    <= 1'b0;
            rd_ptr    <= '0;
            word_idx  <= '0;
            out_valid <= 1'b0;
            last_q    <= 1'b0;
            dma_done  <= 1'b0;
        end else begin
            out_valid <= issue;
            last_q    <= issue
                         && (issue_idx == scope_cfg_pkg::index_t'(scope_cfg_pkg::last_index));
            dma_done  <= last_q;
            if (issue) begin
                // Pointer wraps on its own width, matching the circular buffer
                rd_ptr   <= rd_addr + 1'b1;
                word_idx <= issue_idx + 1'b1;
                active   <= issue_idx != scope_cfg_pkg::index_t'(scope_cfg_pkg::last_index);
            end
        end
    end

    // Address travels one stage alongside the memory read
    always_ff @(posedge clock) begin
        addr_q <= cfg.base_addr + (32'(issue_idx) << scope_cfg_pkg::word_shift);
    end

endmodule

/* capture/capture_buffer.sv */
// Capture memory
// Circular store of sample slots with one write port and
// one read port whose data is registered

`timescale 1ns/1ps

module capture_buffer (
    input  logic                  clock,
    input  logic                  wr_en,
    input  scope_cfg_pkg::index_t wr_addr,
    input  scope_data_pkg::slot_t wr_data,
    input  scope_cfg_pkg::index_t rd_addr,
    output scope_data_pkg::slot_t rd_data
);

    scope_data_pkg::slot_t mem [scope_cfg_pkg::buffer_depth];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/capture_fsm.sv */
// Capture sequencer
// FSM stepping through arm, prefill, trigger wait, post-trigger
// fill and readout. Gates buffer writes and issues the start
// pulse for the readout engine

`timescale 1ns/1ps

module capture_fsm (
    input  logic clock,
    input  logic rst,
    input  logic arm,
    input  logic sample_valid,
    input  logic hit,
    input  logic prefill_done,
    input  logic post_done,
    input  logic write_done,
    output logic count_clear,
    output logic write_en,
    output logic post_phase,
    output logic start,
    output logic busy
);

    typedef enum logic [2:0] {
        idle,
        prefill,
        wait_trigger,
        post,
        readout
    } state_t;

    state_t state;
    logic   capturing;

    assign capturing = (state == prefill) || (state == wait_trigger) || (state == post);

    // Every strobe taken while capturing lands in the buffer,
    // including the trigger sample itself
    assign write_en    = sample_valid && capturing;
    assign post_phase  = state == post;
    assign count_clear = (state == idle) && arm;
    assign busy        = state != idle;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= idle;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                idle: begin
                    if (arm) begin
                        state <= prefill;
                    end
                end
                prefill: begin
                    // Crossings seen here are deliberately not acted on
                    if (prefill_done) begin
                        state <= wait_trigger;
                    end
                end
                wait_trigger: begin
                    if (sample_valid && hit) begin
                        if (post_done) begin
                            state <= readout;
                            start <= 1'b1;
                        end else begin
                            state <= post;
                        end
                    end
                end
                post: begin
                    if (post_done) begin
                        state <= readout;
                        start <= 1'b1;
                    end
                end
                readout: begin
                    // Arm is ignored until the last word has gone out
                    if (write_done) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* source/sample_counter.sv */
// Capture counters
// Write pointer into the circular buffer, saturating fill count
// for the pre-trigger phase and post-trigger slot count

`timescale 1ns/1ps

module sample_counter (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      clear,
    input  logic                      count_en,
    input  logic                      post_phase,
    input  scope_cfg_pkg::scope_cfg_t cfg,
    output scope_cfg_pkg::index_t     wr_ptr,
    output logic                      prefill_done,
    output logic                      post_done
);

    scope_cfg_pkg::index_t fill_count;
    scope_cfg_pkg::index_t post_count;
    scope_cfg_pkg::index_t post_slots;

    // Slots that follow the trigger sample in the window
    assign post_slots = scope_cfg_pkg::index_t'(scope_cfg_pkg::last_index) - cfg.trig_point;

    assign prefill_done = fill_count >= cfg.trig_point;

    // Outside the post phase the flag marks a window without post-trigger
    // slots, so the trigger strobe itself closes the capture
    always_comb begin
        if (post_phase) begin
            post_done = count_en && (post_count == post_slots - 1'b1);
        end else begin
            post_done = count_en && (post_slots == '0);
        end
    end

    always_ff @(posedge clock) begin
        if (rst || clear) begin
            wr_ptr     <= '0;
            fill_count <= '0;
            post_count <= '0;
        end else begin
            if (count_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (fill_count != scope_cfg_pkg::index_t'(scope_cfg_pkg::last_index)) begin
                    fill_count <= fill_count + 1'b1;
                end
            end

            if (!post_phase) begin
                post_count <= '0;
            end else if (count_en) begin
                post_count <= post_count + 1'b1;
            end
        end
    end

endmodule

/* source/trigger_detect.sv */
// Trigger detector
// Selects one channel out of each incoming slot, remembers the
// previous selected sample and flags a rising crossing of the level

`timescale 1ns/1ps

module trigger_detect (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      sample_valid,
    input  scope_data_pkg::slot_t     sample_data,
    input  scope_cfg_pkg::scope_cfg_t cfg,
    output logic                      hit
);

    scope_data_pkg::sample_t selected;
    scope_data_pkg::sample_t level;
    scope_data_pkg::sample_t prev_sample;
    logic                    prev_valid;

    assign selected = sample_data.ch[cfg.channel];
    assign level    = cfg.level;

    // Crossing is judged on signed values
    // Hit is only meaningful while sample_valid is high
    assign hit = sample_valid && prev_valid
                 && (selected >= level) && (prev_sample < level);

    always_ff @(posedge clock) begin
        if (rst) begin
            prev_valid <= 1'b0;
        end else if (sample_valid) begin
            prev_valid <= 1'b1;
        end
    end

    // History follows every strobe, whatever the capture state is
    always_ff @(posedge clock) begin
        if (sample_valid) begin
            prev_sample <= selected;
        end
    end

endmodule

/* source/scope_regs.sv */
// Scope register file
// Decodes register write strobes into the configuration struct
// and turns a write to the arm register into a one-cycle pulse

`timescale 1ns/1ps

module scope_regs (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      reg_write,
    input  scope_cfg_pkg::reg_addr_t  reg_addr,
    input  logic [31:0]               reg_data,
    output scope_cfg_pkg::scope_cfg_t cfg,
    output logic                      arm
);

    always_ff @(posedge clock) begin
        if (rst) begin
            cfg <= '0;
            arm <= 1'b0;
        end else begin
            // Data written to the arm register carries no meaning
            arm <= reg_write && (reg_addr == scope_cfg_pkg::addr_arm);

            if (reg_write) begin
                case (reg_addr)
                    scope_cfg_pkg::addr_base: begin
                        cfg.base_addr <= reg_data;
                    end
                    scope_cfg_pkg::addr_level: begin
                        cfg.level <= reg_data[15:0];
                    end
                    scope_cfg_pkg::addr_channel: begin
                        cfg.channel <= reg_data[1:0];
                    end
                    scope_cfg_pkg::addr_pretrig: begin
                        cfg.trig_point <= reg_data[scope_cfg_pkg::index_width-1:0];
                    end
                    default: begin
                        // Unmapped addresses and the arm register leave cfg alone
                    end
                endcase
            end
        end
    end

endmodule

/* common/scope_data_pkg.sv */
// Scope data package
// Defines the sample type, the slot that groups one sample
// per channel and the addressed word produced by readout

package scope_data_pkg;

    // One signed sample from a single channel
    typedef logic signed [15:0] sample_t;

    // All channels taken on the same strobe
    // Channel 0 sits in the low bits
    typedef struct packed {
        sample_t [scope_cfg_pkg::n_channels-1:0] ch;
    } slot_t;

    // Slot as it leaves the scope together with its target address
    typedef struct packed {
        logic [31:0] addr;
        slot_t       data;
    } out_word_t;

endpackage

/* common/scope_cfg_pkg.sv */
// Scope configuration package
// Holds capture geometry constants, the register address map
// and the configuration struct shared by the register file,
// the trigger unit, the sample counter and the readout engine

package scope_cfg_pkg;

    // Capture geometry
    localparam int n_channels   = 4;
    localparam int buffer_depth = 64;
    localparam int index_width  = $clog2(buffer_depth);
    localparam int last_index   = buffer_depth - 1;

    // Each output word carries one 64-bit slot, so addresses step by 8 bytes
    localparam int word_shift = 3;

    typedef logic [index_width-1:0] index_t;
    typedef logic [2:0]             reg_addr_t;

    // Register map
    localparam reg_addr_t addr_base    = 3'd0;
    localparam reg_addr_t addr_level   = 3'd1;
    localparam reg_addr_t addr_channel = 3'd2;
    localparam reg_addr_t addr_pretrig = 3'd3;
    localparam reg_addr_t addr_arm     = 3'd4;

    // Trigger point counts the slots that precede the trigger sample
    // in the captured window
    typedef struct packed {
        logic [31:0] base_addr;
        logic [15:0] level;
        logic [1:0]  channel;
        index_t      trig_point;
    } scope_cfg_t;

endpackage
